// ==== spiMemory.f ====
logic/spiPkg.sv
logic/memPkg.sv
logic/spiSampler.sv
logic/spiFrameFsm.sv
logic/dataMemory.sv
logic/misoDriver.sv
logic/spiMemory.sv
sim/spiMemoryTb.sv

// ==== sim/spiMemoryTb.sv ====
module spiMemoryTb;

  localparam int halfClk = 10; // sclk half period in clk cycles

  // one SPI frame as the master sends it
  typedef struct packed {
    logic           isRead;
    memPkg::memAddr addr;
    memPkg::memWord data;       // write data, unused for reads
    logic [3:0]     abortAfter; // data bits before csN goes up, 8 = whole frame
    logic [7:0]     gapClk;     // csN high time after the frame
  } frameEntry;

  logic clk;
  logic rstN;
  logic sclk;
  logic csN;
  logic mosi;
  logic miso;
  logic misoEn;

  frameEntry      frameTable[$];
  memPkg::memWord refMem [memPkg::memDepth]; // what memory must hold
  logic [31:0]    lcgState;
  int             errCount;
  int             timeoutCount;
  int             checkCount;

  spiMemory dut (
    .clk    (clk),
    .rstN   (rstN),
    .sclk   (sclk),
    .csN    (csN),
    .mosi   (mosi),
    .miso   (miso),
    .misoEn (misoEn)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic checkWord(input memPkg::memWord got, input memPkg::memWord exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Fail at %0t: read byte %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic addFrame(input logic isRead, input memPkg::memAddr addr,
                          input int abortAfter, input int gapClk);
    frameEntry f;
    f.isRead = isRead;
    f.addr   = addr;
    if (isRead) begin
      f.data = '0;
    end else begin
      lcgState = lcgNext(lcgState);
      f.data   = lcgState[23:16]; // middle bits, low ones cycle fast
    end
    f.abortAfter = 4'(abortAfter);
    f.gapClk     = 8'(gapClk);
    frameTable.push_back(f);
  endtask

  task automatic buildTable();
    addFrame(1'b0, 7'h00, 8, 60); // write then read back
    addFrame(1'b1, 7'h00, 8, 60);
    addFrame(1'b0, 7'h55, 8, 60); // scattered addresses
    addFrame(1'b0, 7'h2a, 8, 60);
    addFrame(1'b0, 7'h7f, 8, 60);
    addFrame(1'b0, 7'h41, 8, 60);
    addFrame(1'b1, 7'h41, 8, 60); // read back in another order
    addFrame(1'b1, 7'h2a, 8, 60);
    addFrame(1'b1, 7'h7f, 8, 60);
    addFrame(1'b1, 7'h55, 8, 60);
    addFrame(1'b0, 7'h2a, 3, 60); // aborted writes keep old data
    addFrame(1'b1, 7'h2a, 8, 60);
    addFrame(1'b0, 7'h55, 7, 60);
    addFrame(1'b1, 7'h55, 8, 60);
    addFrame(1'b0, 7'h13, 8, 20); // back to back from here
    addFrame(1'b1, 7'h13, 8, 20);
    addFrame(1'b0, 7'h13, 8, 20);
    addFrame(1'b1, 7'h13, 8, 20);
    addFrame(1'b0, 7'h6c, 8, 20);
    addFrame(1'b1, 7'h00, 8, 20);
    addFrame(1'b1, 7'h6c, 8, 20);
  endtask

  // csN high, enable must stay off
  task automatic idleGap(input int n);
    repeat (n) begin
      @(posedge clk);
      @(negedge clk);
      checkBit(misoEn, 1'b0, "misoEn while csN high");
    end
  endtask

  task automatic waitMisoEnLow(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (misoEn !== 1'b0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (misoEn !== 1'b0) begin
      timeoutCount++;
      $display("Timeout at %0t: misoEn did not drop within %0d clk after the frame",
               $time, limit);
    end
  endtask

  // mode 0 master, mosi changes on fall, miso sampled on rise
  task automatic runFrame(input frameEntry f, output memPkg::memWord rx);
    logic [15:0] txBits;
    int          nBits;
    txBits = {f.addr, f.isRead, f.data};
    nBits  = 8 + int'(f.abortAfter);
    rx     = '0;
    @(posedge clk);
    csN  <= 1'b0;
    mosi <= txBits[15];
    for (int i = 0; i < nBits; i++) begin
      repeat (halfClk) @(posedge clk);
      sclk <= 1'b1;
      @(negedge clk); // pin edge not through the synchronizer yet
      if (f.isRead && i >= 8) begin
        rx = {rx[6:0], miso}; // msb first
        checkBit(misoEn, 1'b1, "misoEn in read data phase");
      end else begin
        checkBit(misoEn, 1'b0, "misoEn outside read data phase");
      end
      repeat (halfClk) @(posedge clk);
      sclk <= 1'b0;
      if (i < nBits - 1) begin
        mosi <= txBits[14-i];
      end
    end
    repeat (halfClk) @(posedge clk);
    waitMisoEnLow(16);
    @(posedge clk);
    csN  <= 1'b1;
    mosi <= 1'b0;
  endtask

  initial begin
    frameEntry      f;
    memPkg::memWord rx;
    rstN         = 1'b0;
    sclk         = 1'b0;
    csN          = 1'b1;
    mosi         = 1'b0;
    errCount     = 0;
    timeoutCount = 0;
    checkCount   = 0;
    lcgState     = 32'h96a1ee08;
    buildTable();
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    idleGap(8); // enable off right after reset

    foreach (frameTable[i]) begin
      f = frameTable[i];
      runFrame(f, rx);
      if (f.isRead) begin
        checkWord(rx, refMem[f.addr]);
      end else if (f.abortAfter == 4'd8) begin
        refMem[f.addr] = f.data; // only whole frames commit
      end
      idleGap(int'(f.gapClk));
    end

    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== logic/spiMemory.sv ====
module spiMemory (
  input  logic clk,
  input  logic rstN,
  input  logic sclk,
  input  logic csN,
  input  logic mosi,
  output logic miso,
  output logic misoEn
);

  spiPkg::spiEvent spiEvent; // sampled pins
  memPkg::memReq   memReq;
  memPkg::memWord  rdata;
  logic            rdValid;
  logic            shiftOut; // read data phase

  spiSampler uSampler (
    .clk      (clk),
    .rstN     (rstN),
    .sclk     (sclk),
    .csN      (csN),
    .mosi     (mosi),
    .spiEvent (spiEvent)
  );

  spiFrameFsm uFrameFsm (
    .clk      (clk),
    .rstN     (rstN),
    .spiEvent (spiEvent),
    .memReq   (memReq),
    .shiftOut (shiftOut)
  );

  dataMemory uDataMemory (
    .clk     (clk),
    .rstN    (rstN),
    .memReq  (memReq),
    .rdata   (rdata),
    .rdValid (rdValid)
  );

  misoDriver uMisoDriver (
    .clk      (clk),
    .rstN     (rstN),
    .spiEvent (spiEvent),
    .rdata    (rdata),
    .rdValid  (rdValid),
    .shiftOut (shiftOut),
    .miso     (miso),
    .misoEn   (misoEn)
  );

endmodule

// ==== logic/misoDriver.sv ====
module misoDriver (
  input  logic            clk,
  input  logic            rstN,
  input  spiPkg::spiEvent spiEvent,
  input  memPkg::memWord  rdata,
  input  logic            rdValid,
  input  logic            shiftOut,
  output logic            miso,
  output logic            misoEn
);

  memPkg::memWord txShift; // parallel in, serial out

  always_ff @(posedge clk) begin
    if (rdValid) begin
      txShift <= rdata; // bit 7 shows right away
    end else if (spiEvent.sclkFall && shiftOut) begin
      // master samples on rise, next bit goes out on fall
      txShift <= {txShift[6:0], 1'b0};
    end
  end

  assign miso = txShift[7];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      misoEn <= 1'b0;
    end else begin
      misoEn <= shiftOut; // buffer enable, one clk behind
    end
  end

  // FSM drops to idle a cycle after deselect, enable follows one later
  assert property (@(posedge clk) disable iff (!rstN)
    !spiEvent.selected [*2] |=> !misoEn);

endmodule

// ==== logic/dataMemory.sv ====
module dataMemory (
  input  logic           clk,
  input  logic           rstN,
  input  memPkg::memReq  memReq,
  output memPkg::memWord rdata,
  output logic           rdValid
);

  memPkg::memWord mem [memPkg::memDepth]; // filled by first write frames

  // read answer strobe, one cycle behind the request
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= memReq.valid && !memReq.write;
    end
  end

  always_ff @(posedge clk) begin
    if (memReq.valid) begin
      if (memReq.write) begin
        mem[memReq.addr] <= memReq.wdata; // visible next cycle
      end else begin
        rdata <= mem[memReq.addr];
      end
    end
  end

endmodule

// ==== logic/spiFrameFsm.sv ====
module spiFrameFsm (
  input  logic            clk,
  input  logic            rstN,
  input  spiPkg::spiEvent spiEvent,
  output memPkg::memReq   memReq,
  output logic            shiftOut
);

  typedef enum logic [2:0] {
    idle,        // waiting for csN to fall
    address,     // 7 address bits
    rwBit,       // read/write decode
    readIssue,   // read request out, wait for the phase boundary fall
    readShift,   // data bits go out on miso
    writeData,   // 8 data bits come in
    writeCommit  // write request cycle
  } fsmState;

  fsmState state;
  logic [3:0] bitCnt;                     // bits seen in the current field
  logic [spiPkg::dataBits-1:0] rxShift;   // mosi collector
  memPkg::memAddr addrReg;                // held for the whole frame
  logic reqValid;
  logic reqWrite;
  logic addrDone;

  // last address bit arriving this cycle
  assign addrDone = (state == address) && spiEvent.sclkRise &&
                    (bitCnt == 4'(spiPkg::addrBits - 1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= idle;
      bitCnt   <= '0;
      reqValid <= 1'b0;
      reqWrite <= 1'b0;
    end else begin
      reqValid <= 1'b0; // strobe, one cycle only
      if (state != idle && !spiEvent.selected) begin
        // csN up mid frame, drops any partial write
        state  <= idle;
        bitCnt <= '0;
      end else begin
        case (state)
          idle: begin
            if (spiEvent.selectStart) begin
              state  <= address;
              bitCnt <= '0;
            end
          end
          address: begin
            if (addrDone) begin
              state  <= rwBit;
              bitCnt <= '0;
            end else if (spiEvent.sclkRise) begin
              bitCnt <= bitCnt + 4'd1;
            end
          end
          rwBit: begin
            if (spiEvent.sclkRise) begin
              if (spiEvent.mosi) begin // 1 = read
                reqValid <= 1'b1;      // request next cycle
                reqWrite <= 1'b0;
                state    <= readIssue;
              end else begin
                state <= writeData;
              end
            end
          end
          readIssue: begin
            // fall after the r/w bit must not shift the fresh byte
            if (spiEvent.sclkFall) begin
              state  <= readShift;
              bitCnt <= '0;
            end
          end
          readShift: begin
            if (spiEvent.sclkFall) begin
              if (bitCnt == 4'(spiPkg::dataBits - 1)) begin
                state  <= idle; // last bit handed over
                bitCnt <= '0;
              end else begin
                bitCnt <= bitCnt + 4'd1;
              end
            end
          end
          writeData: begin
            if (spiEvent.sclkRise) begin
              if (bitCnt == 4'(spiPkg::dataBits - 1)) begin
                reqValid <= 1'b1;
                reqWrite <= 1'b1;
                state    <= writeCommit;
                bitCnt   <= '0;
              end else begin
                bitCnt <= bitCnt + 4'd1;
              end
            end
          end
          writeCommit: state <= idle; // request goes out this cycle
          default: state <= idle;
        endcase
      end
    end
  end

  // shift path, no reset needed
  always_ff @(posedge clk) begin
    if (spiEvent.sclkRise) rxShift <= {rxShift[spiPkg::dataBits-2:0], spiEvent.mosi};
    if (addrDone) addrReg <= {rxShift[spiPkg::addrBits-2:0], spiEvent.mosi};
  end

  always_comb begin
    memReq.valid = reqValid;
    memReq.write = reqWrite;
    memReq.addr  = addrReg;
    memReq.wdata = rxShift; // full byte by writeCommit
  end

  assign shiftOut = (state == readShift);

  assert property (@(posedge clk) disable iff (!rstN)
    memReq.valid |=> !memReq.valid);

  // request is only raised from inside a selected frame
  assert property (@(posedge clk) disable iff (!rstN)
    memReq.valid |-> spiEvent.selected);

endmodule

// ==== logic/spiSampler.sv ====
module spiSampler (
  input  logic            clk,
  input  logic            rstN,
  input  logic            sclk,
  input  logic            csN,
  input  logic            mosi,
  output spiPkg::spiEvent spiEvent
);

  // first and second synchronizer stages per pin
  logic sclkMeta, sclkSync;
  logic csNMeta, csNSync;
  logic mosiMeta, mosiSync;
  // last synced levels, for edge detect
  logic sclkPrev;
  logic selPrev;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      sclkMeta <= 1'b0; // mode 0 idles low
      sclkSync <= 1'b0;
      csNMeta  <= 1'b1; // deselected
      csNSync  <= 1'b1;
      mosiMeta <= 1'b0;
      mosiSync <= 1'b0;
      sclkPrev <= 1'b0;
      selPrev  <= 1'b0;
      spiEvent <= '0;
    end else begin
      sclkMeta <= sclk;
      sclkSync <= sclkMeta;
      csNMeta  <= csN;
      csNSync  <= csNMeta;
      mosiMeta <= mosi;
      mosiSync <= mosiMeta;

      sclkPrev <= sclkSync;
      selPrev  <= !csNSync;

      // event stage, pin change lands here 3 clk later
      spiEvent.sclkRise    <= sclkSync && !sclkPrev;
      spiEvent.sclkFall    <= !sclkSync && sclkPrev;
      spiEvent.mosi        <= mosiSync; // lines up with its rise
      spiEvent.selected    <= !csNSync;
      spiEvent.selectStart <= !csNSync && !selPrev;
    end
  end

  // sclk edges only come inside a frame
  assert property (@(posedge clk) disable iff (!rstN)
    (spiEvent.sclkRise || spiEvent.sclkFall) |-> spiEvent.selected);

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

  localparam int memDepth = 128; // words

  typedef logic [$clog2(memDepth)-1:0] memAddr; // 7 bits
  typedef logic [7:0] memWord;

  // single-cycle request, always accepted
  typedef struct packed {
    logic   valid; // strobe
    logic   write; // 1 write, 0 read
    memAddr addr;
    memWord wdata;
  } memReq;

endpackage

// ==== logic/spiPkg.sv ====
package spiPkg;

  // frame layout, mode 0, msb first
  localparam int addrBits = 7; // address field
  localparam int dataBits = 8; // data field, in or out

  // sampled pin view, everything already in the clk domain
  typedef struct packed {
    logic sclkRise;    // one clk pulse per synced rising sclk
    logic sclkFall;    // one clk pulse per synced falling sclk
    logic mosi;        // synced data in
    logic selected;    // synced, csN inverted
    logic selectStart; // pulse when selected goes high
  } spiEvent;

endpackage
